// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source; 20 ns clock, reset held low for the first 4 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HalfPeriodNs = 10;
  localparam int ResetCycles  = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Release just after an edge, like the other driven inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== dv/uart_dbg_checker.sv ====
// Bridge monitor; decodes the host and device UART lines, models the protocol and counts errors
`timescale 1ns/1ps
`include "uart_dbg_macros.svh"

module uart_dbg_checker import uart_dbg_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  input  logic rx_line_i,
  input  logic tx_line_i,
  output int   tx_count_o,
  output int   err_count_o,
  output int   pending_o
);

  localparam int ClksPerBit = `UART_DBG_CLKS_PER_BIT;
  localparam int FieldBytes = `UART_DBG_FIELD_BYTES;
  localparam int MemAw      = `UART_DBG_MEM_AW;
  localparam int MemDepth   = 1 << MemAw;

  byte_t model_mem [MemDepth];
  byte_t exp_q [$];

  // One 8N1 frame from either line, sampled mid bit
  task automatic decode_frame(input logic from_dut, output byte_t data, output logic stop_bit);
    logic line;
    int   i;
    data = '0;
    line = 1'b1;
    while (line !== 1'b0) begin
      @(posedge clk);
      line = from_dut ? tx_line_i : rx_line_i;
    end
    repeat (ClksPerBit / 2) @(posedge clk);
    for (i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(posedge clk);
      data[i] = from_dut ? tx_line_i : rx_line_i;
    end
    repeat (ClksPerBit) @(posedge clk);
    stop_bit = from_dut ? tx_line_i : rx_line_i;
  endtask

  task automatic expect_byte(input byte_t b);
    exp_q.push_back(b);
    pending_o = exp_q.size();
  endtask

  ////////////////////
  // Host side model
  ////////////////////

  initial begin : host_side
    byte_t       b;
    logic        stop_bit;
    logic        is_write;
    logic [63:0] addr;
    logic [63:0] len;
    logic [63:0] k;
    logic [63:0] idx;
    int          i;
    tx_count_o  = 0;
    err_count_o = 0;
    pending_o   = 0;
    for (i = 0; i < MemDepth; i++) begin
      model_mem[i] = '0;
    end
    @(posedge rst_n_i);
    forever begin
      decode_frame(1'b0, b, stop_bit);
      if (b == CODE_ACK) begin
        expect_byte(CODE_ACK);
      end else if (b == CMD_READ || b == CMD_WRITE) begin
        is_write = (b == CMD_WRITE);
        addr = '0;
        len  = '0;
        // Both fields little endian
        for (i = 0; i < FieldBytes; i++) begin
          decode_frame(1'b0, b, stop_bit);
          addr[i*8 +: 8] = b;
        end
        for (i = 0; i < FieldBytes; i++) begin
          decode_frame(1'b0, b, stop_bit);
          len[i*8 +: 8] = b;
        end
        expect_byte(CODE_ACK);
        for (k = 0; k < len; k++) begin
          idx = addr + k;
          if (is_write) begin
            decode_frame(1'b0, b, stop_bit);
            model_mem[idx[MemAw-1:0]] = b;
          end else begin
            expect_byte(model_mem[idx[MemAw-1:0]]);
          end
        end
        expect_byte(CODE_EOT);
      end
      // Anything else in idle gets no answer
    end
  end

  ////////////////////
  // Device side compare
  ////////////////////

  initial begin : dut_side
    byte_t got;
    byte_t want;
    logic  stop_bit;
    @(posedge rst_n_i);
    if (tx_line_i !== 1'b1) begin
      $display("tx_o is not idle high when reset is released");
      err_count_o = err_count_o + 1;
    end
    forever begin
      decode_frame(1'b1, got, stop_bit);
      tx_count_o = tx_count_o + 1;
      if (stop_bit !== 1'b1) begin
        $display("Framing problem on tx_o: stop bit of byte %0d is not high", tx_count_o);
        err_count_o = err_count_o + 1;
      end
      if (exp_q.size() == 0) begin
        $display("Extra byte 0x%02h on tx_o while no response was expected", got);
        err_count_o = err_count_o + 1;
      end else begin
        want = exp_q.pop_front();
        pending_o = exp_q.size();
        if (got !== want) begin
          $display("** Error: tx_o expected 0x%02h, got 0x%02h", want, got);
          err_count_o = err_count_o + 1;
        end
      end
    end
  end

endmodule

// ==== dv/uart_dbg_tb.sv ====
// Bridge testbench top; random host transactions over rx_i, responses checked by the monitor
`timescale 1ns/1ps
`include "uart_dbg_macros.svh"

module uart_dbg_tb import uart_dbg_pkg::*; ();

  localparam int ClksPerBit  = `UART_DBG_CLKS_PER_BIT;
  localparam int FieldBytes  = `UART_DBG_FIELD_BYTES;
  localparam int NumTrans    = 60;
  localparam int NumDirected = 3;
  localparam int FrameClks   = 10 * ClksPerBit;
  // Worst case 36 frames per transaction on a 20 ns clock
  localparam longint WatchdogNs =
    longint'(NumTrans + NumDirected) * 36 * FrameClks * 20 + 200000;

  logic        clk;
  logic        rst_n;
  logic        rx_i;
  logic        tx_o;
  int          tx_count;
  int          err_count;
  int          pending;
  int          resp_target;
  logic [15:0] lfsr_q;

  tb_clk_gen clk_gen_inst (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  uart_dbg_top uart_dbg_top_inst (
    .clk     ( clk   ),
    .rst_n_i ( rst_n ),
    .rx_i    ( rx_i  ),
    .tx_o    ( tx_o  )
  );

  uart_dbg_checker checker_inst (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n     ),
    .rx_line_i   ( rx_i      ),
    .tx_line_i   ( tx_o      ),
    .tx_count_o  ( tx_count  ),
    .err_count_o ( err_count ),
    .pending_o   ( pending   )
  );

  ////////////////////
  // Random source
  ////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  ////////////////////
  // Host driver
  ////////////////////

  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      rx_i = frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic send_header(input byte_t cmd, input logic [63:0] addr, input logic [63:0] len);
    int i;
    send_byte(cmd);
    for (i = 0; i < FieldBytes; i++) begin
      send_byte(addr[i*8 +: 8]);
    end
    for (i = 0; i < FieldBytes; i++) begin
      send_byte(len[i*8 +: 8]);
    end
  endtask

  // Block until n more bytes have come back on tx_o
  task automatic await_responses(input int n);
    resp_target = resp_target + n;
    while (tx_count < resp_target) begin
      @(posedge clk);
    end
  endtask

  initial begin : stimulus
    int          t;
    int          i;
    int          kind;
    logic [63:0] addr;
    logic [63:0] len;
    byte_t       b;
    rx_i        = 1'b1;
    lfsr_q      = 16'h0004;
    resp_target = 0;
    @(posedge rst_n);
    // Quiet line first so any byte now is an extra
    repeat (3 * FrameClks) @(posedge clk);
    // Zero lengths give ACK and EOT only
    send_header(CMD_READ, 64'h0, 64'h0);
    await_responses(2);
    send_header(CMD_WRITE, 64'h0, 64'h0);
    await_responses(2);
    // Outside the random window and never written
    send_header(CMD_READ, 64'h40, 64'h4);
    await_responses(6);
    for (t = 0; t < NumTrans; t++) begin
      kind = rand_bits(2);
      if (kind == 0) begin
        send_byte(CODE_ACK);
        await_responses(1);
      end else if (kind == 1 || kind == 2) begin
        // Window around the top of memory so blocks wrap and overlap
        addr[63:32] = rand_bits(32);
        addr[31:8]  = rand_bits(24);
        addr[7:0]   = 8'hE8 + 8'(rand_bits(5));
        len         = rand_bits(4);
        if (kind == 1) begin
          send_header(CMD_READ, addr, len);
          await_responses(int'(len) + 2);
        end else if (len == 0) begin
          send_header(CMD_WRITE, addr, len);
          await_responses(2);
        end else begin
          send_header(CMD_WRITE, addr, len);
          await_responses(1);
          for (i = 0; i < int'(len); i++) begin
            send_byte(byte_t'(rand_bits(8)));
          end
          await_responses(1);
        end
      end else begin
        b = byte_t'(rand_bits(8));
        while (b == CODE_ACK || b == CMD_READ || b == CMD_WRITE) begin
          b = byte_t'(rand_bits(8));
        end
        send_byte(b);
        repeat (2 * FrameClks) @(posedge clk);
      end
    end
    repeat (2 * FrameClks) @(posedge clk);
    if (pending != 0) begin
      $display("Missing bytes: %0d expected responses never appeared on tx_o", pending);
    end
    $display("Run done: %0d transactions, %0d bytes on tx_o, %0d errors, %0d missing",
             NumTrans + NumDirected, tx_count, err_count, pending);
    if (err_count == 0 && pending == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("Timeout after %0d ns: a response never completed or the bridge hung",
             WatchdogNs);
    $display("Run stopped: %0d bytes on tx_o, %0d errors, %0d missing",
             tx_count, err_count, pending);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/uart_dbg_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/dbg_cmd_engine.sv
hw/uart_dbg_top.sv
dv/tb_clk_gen.sv
dv/uart_dbg_checker.sv
dv/uart_dbg_tb.sv

// ==== hw/dbg_cmd_engine.sv ====
// Debug protocol engine; decodes host commands from the receiver and drives the transmitter
`timescale 1ns/1ps
`include "uart_dbg_macros.svh"

module dbg_cmd_engine import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rx_valid_i,
  input  byte_t rx_byte_i,
  input  logic  tx_busy_i,
  output logic  tx_start_o,
  output byte_t tx_byte_o
);

  localparam int unsigned FieldBytes = `UART_DBG_FIELD_BYTES;
  localparam int unsigned IdxW       = $clog2(FieldBytes);
  localparam int unsigned HdrW       = FieldBytes * 8;
  localparam int unsigned MemAw      = `UART_DBG_MEM_AW;
  localparam int unsigned MemDepth   = 2 ** MemAw;

  dbg_state_e       state_q;
  logic             is_write_q;
  logic             in_cmd_q;
  logic [IdxW-1:0]  field_idx_q;
  logic             last_field;
  logic [HdrW-1:0]  hdr_q;
  logic [HdrW-1:0]  hdr_next;
  logic [MemAw-1:0] addr_q;
  logic [HdrW-1:0]  len_q;
  logic             tx_free;
  logic             wr_en;
  logic             rd_en;
  logic             data_step;
  byte_t            mem_q [MemDepth];

  assign tx_free    = !tx_busy_i;
  assign last_field = (field_idx_q == IdxW'(FieldBytes - 1));
  // Little endian so each new byte enters at the top
  assign hdr_next   = {rx_byte_i, hdr_q[HdrW-1:8]};

  assign wr_en     = (state_q == DATA) && is_write_q && rx_valid_i;
  assign rd_en     = (state_q == DATA) && !is_write_q && tx_free;
  assign data_step = wr_en | rd_en;

  ////////////////////
  // Header assembly
  ////////////////////

  always_ff @(posedge clk) begin
    if (rx_valid_i && (state_q == ADDR || state_q == LEN)) begin
      hdr_q <= hdr_next;
    end
  end

  ////////////////////
  // Protocol FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      is_write_q  <= 1'b0;
      in_cmd_q    <= 1'b0;
      field_idx_q <= '0;
      addr_q      <= '0;
      len_q       <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (rx_valid_i) begin
            field_idx_q <= '0;
            case (rx_byte_i)
              CODE_ACK: begin
                // Challenge gets a lone ACK
                in_cmd_q <= 1'b0;
                state_q  <= ACK;
              end
              CMD_READ: begin
                in_cmd_q   <= 1'b1;
                is_write_q <= 1'b0;
                state_q    <= ADDR;
              end
              CMD_WRITE: begin
                in_cmd_q   <= 1'b1;
                is_write_q <= 1'b1;
                state_q    <= ADDR;
              end
              default: ;
            endcase
          end
        end
        ADDR: begin
          if (rx_valid_i) begin
            field_idx_q <= field_idx_q + 1'b1;
            if (last_field) begin
              // Upper address bits drop out and access wraps on the memory
              addr_q  <= hdr_next[MemAw-1:0];
              state_q <= LEN;
            end
          end
        end
        LEN: begin
          if (rx_valid_i) begin
            field_idx_q <= field_idx_q + 1'b1;
            if (last_field) begin
              len_q   <= hdr_next;
              state_q <= ACK;
            end
          end
        end
        ACK: begin
          if (tx_free) begin
            if (!in_cmd_q) begin
              state_q <= IDLE;
            end else if (len_q == '0) begin
              state_q <= EOT;
            end else begin
              state_q <= DATA;
            end
          end
        end
        DATA: begin
          if (data_step) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == HdrW'(1)) begin
              state_q <= EOT;
            end
          end
        end
        EOT: begin
          if (tx_free) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Byte memory cleared by reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_q <= '{default: '0};
    end else if (wr_en) begin
      mem_q[addr_q] <= rx_byte_i;
    end
  end

  ////////////////////
  // Transmit side
  ////////////////////

  always_comb begin
    tx_start_o = 1'b0;
    tx_byte_o  = CODE_ACK;
    unique case (state_q)
      ACK: begin
        tx_start_o = tx_free;
      end
      DATA: begin
        tx_start_o = rd_en;
        tx_byte_o  = mem_q[addr_q];
      end
      EOT: begin
        tx_start_o = tx_free;
        tx_byte_o  = CODE_EOT;
      end
      default: ;
    endcase
  end

  a_wr_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_en |-> (len_q != '0))
    else $error("Write data accepted with no length remaining");

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q inside {IDLE, ADDR, LEN, ACK, DATA, EOT})
    else $error("Engine state left the legal set");

endmodule

// ==== hw/uart_dbg_macros.svh ====
// Bridge constants for bit timing, memory size and header fields; include in RTL and testbench
`ifndef UART_DBG_MACROS_SVH
`define UART_DBG_MACROS_SVH

////////////////////
// UART timing
////////////////////

// Clock cycles per UART bit, kept small for simulation
`define UART_DBG_CLKS_PER_BIT 16

////////////////////
// Local memory
////////////////////

// Address width of the byte memory, 256 bytes
`define UART_DBG_MEM_AW 8

////////////////////
// Command header
////////////////////

// Bytes in each little-endian address and length field
`define UART_DBG_FIELD_BYTES 8

`endif

// ==== hw/uart_dbg_pkg.sv ====
// Byte type, protocol codes and engine states; import wherever the bridge protocol is handled
package uart_dbg_pkg;

  // One protocol byte on the UART
  typedef logic [7:0] byte_t;

  ////////////////////
  // Protocol codes
  ////////////////////

  typedef enum logic [7:0] {
    CODE_EOT  = 8'h04,
    CODE_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12
  } dbg_code_e;

  // Command engine FSM
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    LEN,
    ACK,
    DATA,
    EOT
  } dbg_state_e;

endpackage

// ==== hw/uart_dbg_top.sv ====
// UART debug bridge top; connect rx_i and tx_o to the host serial line
`timescale 1ns/1ps

module uart_dbg_top import uart_dbg_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  input  logic rx_i,
  output logic tx_o
);

  logic  rx_valid;
  byte_t rx_byte;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;

  // Host to bridge
  uart_rx uart_rx_inst (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .rx_i       ( rx_i     ),
    .rx_valid_o ( rx_valid ),
    .rx_byte_o  ( rx_byte  )
  );

  dbg_cmd_engine dbg_cmd_engine_inst (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .rx_valid_i ( rx_valid ),
    .rx_byte_i  ( rx_byte  ),
    .tx_busy_i  ( tx_busy  ),
    .tx_start_o ( tx_start ),
    .tx_byte_o  ( tx_byte  )
  );

  // Bridge to host
  uart_tx uart_tx_inst (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .tx_start_i ( tx_start ),
    .tx_byte_i  ( tx_byte  ),
    .tx_busy_o  ( tx_busy  ),
    .tx_o       ( tx_o     )
  );

endmodule

// ==== hw/uart_rx.sv ====
// 8N1 UART receiver; oversamples rx_i and pulses rx_valid_o once per received frame
`timescale 1ns/1ps
`include "uart_dbg_macros.svh"

module uart_rx import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  localparam int unsigned ClksPerBit = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CntW       = $clog2(ClksPerBit);
  // Frame slots are 0 start, 1 to 8 data, 9 stop
  localparam logic [3:0]  StopSlot   = 4'd9;

  logic [2:0]      sync_q;
  logic            rx_s;
  logic            start_edge;
  logic            active_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      slot_q;
  logic            sample;
  byte_t           shift_q;

  // Two synchronizer flops plus one for edge detection
  assign rx_s       = sync_q[1];
  assign start_edge = sync_q[2] & ~sync_q[1] & ~active_q;
  assign sample     = active_q && (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[1:0], rx_i};
    end
  end

  ////////////////////
  // Bit timing
  ////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q   <= 1'b0;
      cnt_q      <= '0;
      slot_q     <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (start_edge) begin
        // First sample lands mid start bit
        active_q <= 1'b1;
        cnt_q    <= CntW'(ClksPerBit / 2 - 1);
        slot_q   <= '0;
      end else if (sample) begin
        cnt_q  <= CntW'(ClksPerBit - 1);
        slot_q <= slot_q + 4'd1;
        if (slot_q == StopSlot) begin
          active_q   <= 1'b0;
          rx_valid_o <= 1'b1;
        end else if (slot_q == '0 && rx_s) begin
          // Line back high at mid start bit, treat as a glitch
          active_q <= 1'b0;
        end
      end else if (active_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Data bits come in LSB first
  always_ff @(posedge clk) begin
    if (sample && slot_q != '0 && slot_q != StopSlot) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

  a_rx_valid_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    rx_valid_o |=> !rx_valid_o)
    else $error("rx_valid_o high for two cycles in a row");

endmodule

// ==== hw/uart_tx.sv ====
// 8N1 UART transmitter; send a byte with a one-cycle start strobe, busy covers the whole frame
`timescale 1ns/1ps
`include "uart_dbg_macros.svh"

module uart_tx import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  tx_start_i,
  input  byte_t tx_byte_i,
  output logic  tx_busy_o,
  output logic  tx_o
);

  localparam int unsigned ClksPerBit = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CntW       = $clog2(ClksPerBit);
  localparam logic [3:0]  StopSlot   = 4'd9;

  logic            busy_q;
  logic            tx_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      slot_q;
  logic            bit_end;
  // Eight data bits with the stop bit on top
  logic [8:0]      shift_q;

  assign bit_end = busy_q && (cnt_q == '0);

  ////////////////////
  // Frame control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      tx_q   <= 1'b1;
      cnt_q  <= '0;
      slot_q <= '0;
    end else begin
      if (tx_start_i && !busy_q) begin
        // Start bit goes out the cycle after the strobe
        busy_q <= 1'b1;
        tx_q   <= 1'b0;
        cnt_q  <= CntW'(ClksPerBit - 1);
        slot_q <= '0;
      end else if (bit_end) begin
        cnt_q <= CntW'(ClksPerBit - 1);
        if (slot_q == StopSlot) begin
          busy_q <= 1'b0;
        end else begin
          tx_q   <= shift_q[0];
          slot_q <= slot_q + 4'd1;
        end
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // LSB first, ones shifted in keep the line idle high
  always_ff @(posedge clk) begin
    if (tx_start_i && !busy_q) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx_busy_o = busy_q;
  assign tx_o      = tx_q;

  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_start_i |-> !tx_busy_o)
    else $error("tx_start_i raised while the transmitter is busy");

endmodule
